// ==== nnClassifier.f ====
+incdir+hdl
+incdir+sim
hdl/nnPkg.sv
hdl/reluNode.sv
hdl/classSelect.sv
hdl/nnClassifier.sv
sim/nnClassifierTb.sv

// ==== Bender.yml ====
package:
  name: nn_classifier

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/nnPkg.sv
      - hdl/reluNode.sv
      - hdl/classSelect.sv
      - hdl/nnClassifier.sv
  - target: simulation
    include_dirs:
      - hdl
      - sim
    files:
      - sim/nnClassifierTb.sv

// ==== sim/nnModel.svh ====
`ifndef NN_MODEL_SVH
`define NN_MODEL_SVH

// Class index, winning score and margin, from the high bit down.
typedef logic [2*`NN_WIDTH:0] resultT;

// One neuron. The sum is kept in a full integer and cut to 16 bits at the end,
// which wraps the same way as a 16-bit adder.
function automatic logic [`NN_WIDTH-1:0] expectNode(
	input logic [`NN_INPUTS*`NN_WIDTH-1:0] actsIn,
	input logic [`NN_INPUTS*`NN_WIDTH-1:0] weights,
	input logic [`NN_WIDTH-1:0] bias
);
	int acc;
	int a;
	int w;
	logic [`NN_WIDTH-1:0] sum;
	acc = $signed(bias);
	for (int i = 0; i < `NN_INPUTS; i++)
	begin
		a = $signed(actsIn[i*`NN_WIDTH +: `NN_WIDTH]);
		w = $signed(weights[i*`NN_WIDTH +: `NN_WIDTH]);
		acc = acc + a * w;
	end
	sum = acc[`NN_WIDTH-1:0];
	return sum[`NN_WIDTH-1] ? '0 : sum;
endfunction

// Class 1 wins only with a strictly greater score.
function automatic resultT expectResult(input logic [`NN_INPUTS*`NN_WIDTH-1:0] actsIn);
	logic [`NN_WIDTH-1:0] s0;
	logic [`NN_WIDTH-1:0] s1;
	s0 = expectNode(actsIn, `NN_WEIGHTS0, `NN_BIAS0);
	s1 = expectNode(actsIn, `NN_WEIGHTS1, `NN_BIAS1);
	if (s1 > s0)
	begin
		return {1'b1, s1, s1 - s0};
	end
	return {1'b0, s0, s0 - s1};
endfunction

`endif

// ==== sim/nnClassifierTb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "nn_config.svh"

module nnClassifierTb;

	import nnPkg::*;

	`include "nnModel.svh"

	localparam int WAIT_LIMIT = 50;

	logic clk;
	logic reset;
	logic inValid;
	actVecT acts;
	logic outValid;
	classT classIdx;
	scoreT score;
	scoreT margin;

	integer seed;
	int errors;
	int checks;
	resultT expected [$];
	resultT want;
	resultT lastSeen;
	logic haveLast;

	nnClassifier u_dut (
		.clk(clk),
		.reset(reset),
		.inValid(inValid),
		.acts(acts),
		.outValid(outValid),
		.classIdx(classIdx),
		.score(score),
		.margin(margin)
	);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic checkValue(input string name, input logic [`NN_WIDTH-1:0] got,
		input logic [`NN_WIDTH-1:0] exp);
		checks++;
		assert (got === exp)
		else
		begin
			errors++;
			$display("** Error: %s = %h, expected %h at %0t", name, got, exp, $time);
		end
	endtask

	// Outputs are read at the clock edge, before the DUT updates them.
	always @(posedge clk)
	begin
		if (!reset && outValid)
		begin
			if (expected.size() == 0)
			begin
				errors++;
				$display("outValid came at %0t with no sample pending", $time);
			end
			else
			begin
				want = expected.pop_front();
				checkValue("classIdx", classIdx, want[2*`NN_WIDTH]);
				checkValue("score", score, want[2*`NN_WIDTH-1:`NN_WIDTH]);
				checkValue("margin", margin, want[`NN_WIDTH-1:0]);
			end
		end
		else if (!reset && haveLast)
		begin
			checkValue("classIdx", classIdx, lastSeen[2*`NN_WIDTH]);
			checkValue("score", score, lastSeen[2*`NN_WIDTH-1:`NN_WIDTH]);
			checkValue("margin", margin, lastSeen[`NN_WIDTH-1:0]);
		end
		lastSeen = {classIdx, score, margin};
		haveLast = !reset;
	end

	function automatic actVecT randomActs();
		actVecT v;
		for (int i = 0; i < `NN_INPUTS; i++)
		begin
			v[i] = $random(seed) % 200;
		end
		return v;
	endfunction

	task automatic checkIdle();
		checkValue("outValid", outValid, '0);
		checkValue("classIdx", classIdx, '0);
		checkValue("score", score, '0);
		checkValue("margin", margin, '0);
	endtask

	task automatic sendIsolated(input actVecT sample);
		int waited;
		@(posedge clk);
		inValid <= 1'b1;
		acts <= sample;
		expected.push_back(expectResult(sample));
		@(posedge clk);
		inValid <= 1'b0;
		waited = 1;
		while (!outValid && waited < WAIT_LIMIT)
		begin
			@(posedge clk);
			waited++;
		end
		if (!outValid)
		begin
			errors++;
			$display("Timed out waiting for outValid after an isolated sample");
		end
		else
		begin
			// The strobe is read one edge after it rises.
			checks++;
			assert (waited == 5)
			else
			begin
				errors++;
				$display("outValid came %0d cycles after inValid instead of 4", waited - 1);
			end
		end
	endtask

	task automatic sendDirected(input actVecT sample, input resultT intended);
		checks++;
		assert (expectResult(sample) === intended)
		else
		begin
			errors++;
			$display("A directed sample does not give its intended class, score and margin");
		end
		sendIsolated(sample);
	endtask

	task automatic countPulses(input int target);
		int pulses;
		int waited;
		bit started;
		pulses = 0;
		waited = 0;
		started = 1'b0;
		while (pulses < target && waited < target + WAIT_LIMIT)
		begin
			@(posedge clk);
			waited++;
			if (outValid)
			begin
				pulses++;
				started = 1'b1;
			end
			else if (started)
			begin
				errors++;
				$display("Gap in outValid after %0d of %0d pulses", pulses, target);
				started = 1'b0;
			end
		end
		if (pulses < target)
		begin
			errors++;
			$display("Timed out with %0d of %0d outValid pulses", pulses, target);
		end
	endtask

	task automatic finishTest(input string name, input int errBefore);
		repeat (3) @(posedge clk);
		if (expected.size() != 0)
		begin
			errors++;
			$display("%0d expected results never came out", expected.size());
			expected.delete();
		end
		$display("%s finished with %0d errors", name, errors - errBefore);
	endtask

	initial
	begin
		actVecT sample;
		int errBefore;
		seed = 32'hf3c3;
		errors = 0;
		checks = 0;
		haveLast = 1'b0;
		reset = 1'b1;
		inValid = 1'b0;
		acts = '0;

		// Outputs are unknown until the first edge has passed.
		errBefore = errors;
		for (int i = 0; i < 5; i++)
		begin
			@(posedge clk);
			if (i > 0)
			begin
				checkIdle();
			end
		end
		reset <= 1'b0;
		repeat (4)
		begin
			@(posedge clk);
			checkIdle();
		end
		finishTest("Reset", errBefore);

		errBefore = errors;
		for (int n = 0; n < 30; n++)
		begin
			sendIsolated(randomActs());
			repeat ($unsigned($random(seed)) % 4) @(posedge clk);
		end
		finishTest("Isolated samples", errBefore);

		errBefore = errors;
		fork
			begin
				for (int n = 0; n < 200; n++)
				begin
					@(posedge clk);
					sample = randomActs();
					inValid <= 1'b1;
					acts <= sample;
					expected.push_back(expectResult(sample));
				end
				@(posedge clk);
				inValid <= 1'b0;
			end
			countPulses(200);
		join
		finishTest("Back-to-back samples", errBefore);

		// Weight 9 is positive in both neurons, so a negative activation there sinks both.
		errBefore = errors;
		sample = '0;
		sample[9] = -16'sd100;
		sendDirected(sample, {1'b0, 16'h0000, 16'h0000});
		sample = '0;
		sample[0] = 16'sd10;
		sendDirected(sample, {1'b0, 16'h012F, 16'h012F});
		sample = '0;
		sample[1] = 16'sd10;
		sendDirected(sample, {1'b1, 16'h012F, 16'h012F});
		finishTest("ReLU clamp", errBefore);

		// Words 2 and 3 add the same to both sums, and word 11 closes the bias gap.
		errBefore = errors;
		sample = '0;
		sample[2] = 16'sd10;
		sample[3] = 16'sd10;
		sample[11] = -16'sd2;
		sendDirected(sample, {1'b0, 16'h0027, 16'h0000});
		repeat (6) @(posedge clk);
		sendIsolated(randomActs());
		repeat (6) @(posedge clk);
		finishTest("Ties and holding", errBefore);

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
		begin
			$display("Test passed");
		end
		else
		begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== hdl/nnClassifier.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "nn_config.svh"

module nnClassifier (
	input logic clk,
	input logic reset,
	input logic inValid,
	input nnPkg::actVecT acts,
	output logic outValid,
	output nnPkg::classT classIdx,
	output nnPkg::scoreT score,
	output nnPkg::scoreT margin
);

	import nnPkg::*;

	logic node0Valid;
	logic node1Valid;
	scoreT node0Score;
	scoreT node1Score;

	// Both neurons see the same sample in the same cycle.
	reluNode #(
		.WEIGHTS(`NN_WEIGHTS0),
		.BIAS(`NN_BIAS0)
	) u_node0 (
		.clk(clk),
		.reset(reset),
		.inValid(inValid),
		.acts(acts),
		.outValid(node0Valid),
		.score(node0Score)
	);

	reluNode #(
		.WEIGHTS(`NN_WEIGHTS1),
		.BIAS(`NN_BIAS1)
	) u_node1 (
		.clk(clk),
		.reset(reset),
		.inValid(inValid),
		.acts(acts),
		.outValid(node1Valid),
		.score(node1Score)
	);

	// Neuron 0 paces the selector. The strobe of neuron 1 is only checked.
	classSelect u_select (
		.clk(clk),
		.reset(reset),
		.inValid(node0Valid),
		.score0(node0Score),
		.score1(node1Score),
		.checkValid(node1Valid),
		.outValid(outValid),
		.classIdx(classIdx),
		.score(score),
		.margin(margin)
	);

endmodule

`default_nettype wire

// ==== hdl/classSelect.sv ====
`timescale 1ns/10ps
`default_nettype none

module classSelect (
	input logic clk,
	input logic reset,
	input logic inValid,
	input nnPkg::scoreT score0,
	input nnPkg::scoreT score1,
	input logic checkValid,
	output logic outValid,
	output nnPkg::classT classIdx,
	output nnPkg::scoreT score,
	output nnPkg::scoreT margin
);

	import nnPkg::*;

	classT pick;
	scoreT winScore;
	scoreT loseScore;

	// Class 1 must be strictly greater, so a tie goes to class 0.
	always_comb
	begin
		pick = score1 > score0;
		if (pick)
		begin
			winScore = score1;
			loseScore = score0;
		end
		else
		begin
			winScore = score0;
			loseScore = score1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			outValid <= 1'b0;
		end
		else
		begin
			outValid <= inValid;
		end
	end

	// The result registers load only on a strobe and hold in between.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			classIdx <= '0;
			score <= '0;
			margin <= '0;
		end
		else if (inValid)
		begin
			classIdx <= pick;
			score <= winScore;
			margin <= winScore - loseScore;
		end
	end

	// Both neurons share one pipeline depth, so their strobes must line up.
	strobesAligned: assert property (
		@(posedge clk) disable iff (reset)
		checkValid == inValid
	)
	else
		$error("classSelect: neuron strobes differ");

endmodule

`default_nettype wire

// ==== hdl/reluNode.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "nn_config.svh"

module reluNode #(
	parameter logic [`NN_INPUTS*`NN_WIDTH-1:0] WEIGHTS = `NN_WEIGHTS0,
	parameter logic [`NN_WIDTH-1:0] BIAS = `NN_BIAS0
) (
	input logic clk,
	input logic reset,
	input logic inValid,
	input nnPkg::actVecT acts,
	output logic outValid,
	output nnPkg::scoreT score
);

	import nnPkg::*;

	// Bit 0 follows the input register, bit 1 the sum register and bit 2 the ReLU register.
	logic [2:0] validPipe;

	actVecT actsReg;

	// Each product keeps only its low 16 bits, the same as the sum that adds them.
	actT prods [`NN_INPUTS];

	logic [`NN_WIDTH-1:0] sumNext;
	logic [`NN_WIDTH-1:0] sumReg;

	// The strobe moves along beside the data, so several samples can be in flight.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			validPipe <= '0;
		end
		else
		begin
			validPipe <= {validPipe[1:0], inValid};
		end
	end

	assign outValid = validPipe[2];

	// Stage 1 captures the activations.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			actsReg <= '0;
		end
		else if (inValid)
		begin
			actsReg <= acts;
		end
	end

	genvar g;
	generate
		for (g = 0; g < `NN_INPUTS; g++)
		begin : genProd
			assign prods[g] = actsReg[g] * WEIGHTS[g*`NN_WIDTH +: `NN_WIDTH];
		end
	endgenerate

	// The sum starts from the bias and wraps around.
	always_comb
	begin
		sumNext = BIAS;
		for (int i = 0; i < `NN_INPUTS; i++)
		begin
			sumNext = sumNext + prods[i];
		end
	end

	// Stage 2 holds the weighted sum.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			sumReg <= '0;
		end
		else if (validPipe[0])
		begin
			sumReg <= sumNext;
		end
	end

	// Stage 3 is the ReLU. A sum with the sign bit set gives zero.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			score <= '0;
		end
		else if (validPipe[1])
		begin
			if (sumReg[`NN_WIDTH-1])
			begin
				score <= '0;
			end
			else
			begin
				score <= sumReg;
			end
		end
	end

	scoreNonNegative: assert property (
		@(posedge clk) disable iff (reset)
		!score[`NN_WIDTH-1]
	)
	else
		$error("reluNode: score has its sign bit set");

	// Every strobe in comes out exactly three cycles later.
	latencyIn: assert property (
		@(posedge clk) disable iff (reset)
		inValid |-> ##3 outValid
	)
	else
		$error("reluNode: outValid missing three cycles after inValid");

	// And no strobe comes out without one three cycles earlier.
	latencyOut: assert property (
		@(posedge clk) disable iff (reset)
		outValid |-> $past(inValid, 3)
	)
	else
		$error("reluNode: outValid without inValid three cycles before");

endmodule

`default_nettype wire

// ==== hdl/nnPkg.sv ====
`default_nettype none

`include "nn_config.svh"

package nnPkg;

	// One activation in two's complement.
	typedef logic signed [`NN_WIDTH-1:0] actT;

	// All activations of one sample, with element 0 in the low word.
	typedef actT [`NN_INPUTS-1:0] actVecT;

	// A neuron output. The ReLU keeps it non-negative, so it is treated as unsigned.
	typedef logic [`NN_WIDTH-1:0] scoreT;

	// Index of the winning class.
	typedef logic classT;

endpackage

`default_nettype wire

// ==== hdl/nn_config.svh ====
`ifndef NN_CONFIG_SVH
`define NN_CONFIG_SVH

// Width of an activation, a weight, a sum and a score.
`define NN_WIDTH 16

// Activations per sample.
`define NN_INPUTS 15

// Class 0 weights, word 14 first and word 0 last.
// In decimal, words 0 to 14 are 29, -22, 6, -2, 64, -15, 25, -5, 18, 61, -39, 7, -36, 7, 32.
`define NN_WEIGHTS0 { \
	16'h0020, 16'h0007, 16'hFFDC, 16'h0007, 16'hFFD9, \
	16'h003D, 16'h0012, 16'hFFFB, 16'h0019, 16'hFFF1, \
	16'h0040, 16'hFFFE, 16'h0006, 16'hFFEA, 16'h001D \
}

`define NN_BIAS0 16'h000D

// Class 1 weights, in the same order.
// In decimal, words 0 to 14 are -17, 31, -8, 12, -40, 22, -9, 14, -26, 5, 44, -3, 28, -11, -19.
`define NN_WEIGHTS1 { \
	16'hFFED, 16'hFFF5, 16'h001C, 16'hFFFD, 16'h002C, \
	16'h0005, 16'hFFE6, 16'h000E, 16'hFFF7, 16'h0016, \
	16'hFFD8, 16'h000C, 16'hFFF8, 16'h001F, 16'hFFEF \
}

// Bias of class 1 is -7.
`define NN_BIAS1 16'hFFF9

`endif
